// ==== logic/core_pkg.sv ====
// Data width, ALU opcode and operand-select enums, and the micro-op and writeback structs.
package core_pkg;

    localparam int xlen = 32;

    // ----------------------------------------------------------------------
    // Opcodes and operand selects
    // ----------------------------------------------------------------------

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_slt, // Signed compare.
        alu_lui  // Operand two shifted left by 12.
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_rf,
        src1_pc,
        src1_zero,
        src1_cntid
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_rf,
        src2_imm,
        src2_cntl, // Low half of the stable counter.
        src2_cnth  // High half of the stable counter.
    } src2_sel_e;

    // ----------------------------------------------------------------------
    // Pipeline records
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic            valid;
        alu_op_e         op;
        src1_sel_e       src1_sel;
        src2_sel_e       src2_sel;
        logic [4:0]      rd;
        logic [4:0]      rj;
        logic [4:0]      rk;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
    } issue_uop_t;

    // Operands are resolved here, so the execute lane sees only values.
    typedef struct packed {
        logic            valid;
        alu_op_e         op;
        logic [4:0]      rd;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] operand_a;
        logic [xlen-1:0] operand_b;
    } read_uop_t;

    typedef struct packed {
        logic            en;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
        logic [xlen-1:0] pc;
    } wb_t;

endpackage

// ==== logic/pipe_control.sv ====
// Pipeline control for stall hold, flush kill and the read-after-write hazard bubble.
`timescale 1ns/1ps

module pipe_control import core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  logic       flush,
    input  issue_uop_t issue0,
    input  issue_uop_t issue1,
    input  logic [4:0] read_rd0,
    input  logic [4:0] read_rd1,
    input  logic       read_valid0,
    input  logic       read_valid1,
    output logic       hold,
    output logic       bubble,
    output logic       kill,
    output logic       issue_ready
);

    logic hazard;

    // True when a valid micro-op reads rd from the register file.
    function automatic logic reads_reg(input issue_uop_t u, input logic [4:0] rd);
        logic hit_j;
        logic hit_k;
        hit_j = (u.src1_sel == src1_rf) && (u.rj == rd);
        hit_k = (u.src2_sel == src2_rf) && (u.rk == rd);
        return u.valid && (rd != 5'd0) && (hit_j || hit_k);
    endfunction

    // ----------------------------------------------------------------------
    // Hazard detection
    // ----------------------------------------------------------------------

    // The bubble empties the read stage, so the hazard lasts one cycle.
    // The producer then sits in execute and is bypassed.
    always_comb begin
        hazard = 1'b0;
        if (read_valid0 && (reads_reg(issue0, read_rd0) || reads_reg(issue1, read_rd0)))
            hazard = 1'b1;
        if (read_valid1 && (reads_reg(issue0, read_rd1) || reads_reg(issue1, read_rd1)))
            hazard = 1'b1;
    end

    // ----------------------------------------------------------------------
    // Outputs to the datapath and the issuer
    // ----------------------------------------------------------------------

    assign kill        = reset || flush;
    assign hold        = stall;
    assign bubble      = hazard;
    assign issue_ready = !(stall || flush || hazard);

endmodule

// ==== logic/register_file.sv ====
// Register array with dual write ports, operand select and bypass, stable counter, read stage.
`timescale 1ns/1ps

module register_file import core_pkg::*; #(
    parameter logic [xlen-1:0] counter_id = 32'h0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       hold,
    input  logic       bubble,
    input  logic       kill,
    input  issue_uop_t issue0,
    input  issue_uop_t issue1,
    input  wb_t        wb0,
    input  wb_t        wb1,
    output read_uop_t  read0,
    output read_uop_t  read1
);

    logic [xlen-1:0] regs [32];
    logic [63:0]     stable_counter;
    logic            wr0_live;
    logic            wr1_live;
    read_uop_t       next0;
    read_uop_t       next1;

    // ----------------------------------------------------------------------
    // Write ports
    // ----------------------------------------------------------------------

    // Lane 0 loses when both lanes target the same register.
    assign wr0_live = wb0.en && (wb0.rd != 5'd0) && !(wb1.en && (wb1.rd == wb0.rd));
    assign wr1_live = wb1.en && (wb1.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (wr0_live)
            regs[wb0.rd] <= wb0.data;
        if (wr1_live)
            regs[wb1.rd] <= wb1.data;
    end

    always_ff @(posedge clk) begin
        if (reset)
            stable_counter <= 64'd0;
        else
            stable_counter <= stable_counter + 64'd1;
    end

    // ----------------------------------------------------------------------
    // Operand read
    // ----------------------------------------------------------------------

    // Register 0 first, then the two writes landing this cycle, then the array.
    function automatic logic [xlen-1:0] read_reg(input logic [4:0] addr);
        if (addr == 5'd0)
            return '0;
        else if (wr0_live && (wb0.rd == addr))
            return wb0.data;
        else if (wr1_live && (wb1.rd == addr))
            return wb1.data;
        else
            return regs[addr];
    endfunction

    function automatic read_uop_t build_read(input issue_uop_t u);
        read_uop_t r;
        r.valid = u.valid;
        r.op    = u.op;
        r.rd    = u.rd;
        r.pc    = u.pc;
        case (u.src1_sel)
            src1_rf:    r.operand_a = read_reg(u.rj);
            src1_pc:    r.operand_a = u.pc;
            src1_zero:  r.operand_a = '0;
            src1_cntid: r.operand_a = counter_id;
            default:    r.operand_a = '0;
        endcase
        case (u.src2_sel)
            src2_rf:   r.operand_b = read_reg(u.rk);
            src2_imm:  r.operand_b = u.imm;
            src2_cntl: r.operand_b = stable_counter[31:0];
            src2_cnth: r.operand_b = stable_counter[63:32];
            default:   r.operand_b = '0;
        endcase
        return r;
    endfunction

    always_comb begin
        next0       = build_read(issue0);
        next1       = build_read(issue1);
        next0.valid = issue0.valid && !bubble; // A held pair enters as a bubble.
        next1.valid = issue1.valid && !bubble;
    end

    // ----------------------------------------------------------------------
    // Read-stage register
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (kill) begin
            read0.valid <= 1'b0;
            read1.valid <= 1'b0;
        end else if (!hold) begin
            read0 <= next0;
            read1 <= next1;
        end
    end

endmodule

// ==== logic/exec_unit.sv ====
// Single-cycle integer execute lane: ALU and result register driving writeback.
`timescale 1ns/1ps

module exec_unit import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      hold,
    input  logic      kill,
    input  read_uop_t read_in,
    output wb_t       wb
);

    logic [xlen-1:0] alu_result;
    logic [4:0]      shamt;
    logic            res_valid;
    logic [4:0]      res_rd;
    logic [xlen-1:0] res_data;
    logic [xlen-1:0] res_pc;

    assign shamt = read_in.operand_b[4:0];

    // ----------------------------------------------------------------------
    // ALU
    // ----------------------------------------------------------------------

    always_comb begin
        case (read_in.op)
            alu_add: alu_result = read_in.operand_a + read_in.operand_b;
            alu_sub: alu_result = read_in.operand_a - read_in.operand_b;
            alu_and: alu_result = read_in.operand_a & read_in.operand_b;
            alu_or:  alu_result = read_in.operand_a | read_in.operand_b;
            alu_xor: alu_result = read_in.operand_a ^ read_in.operand_b;
            alu_sll: alu_result = read_in.operand_a << shamt;
            alu_srl: alu_result = read_in.operand_a >> shamt;
            alu_slt: begin
                alu_result = {31'd0, $signed(read_in.operand_a) < $signed(read_in.operand_b)};
            end
            alu_lui: alu_result = read_in.operand_b << 12;
            default: alu_result = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Result register
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset || kill) begin
            res_valid <= 1'b0;
        end else if (!hold) begin
            res_valid <= read_in.valid;
            res_rd    <= read_in.rd;
            res_data  <= alu_result;
            res_pc    <= read_in.pc;
        end
    end

    // A held result commits on its first cycle after the stall clears.
    assign wb.en   = res_valid && !hold && !kill;
    assign wb.rd   = res_rd;
    assign wb.data = res_data;
    assign wb.pc   = res_pc;

endmodule

// ==== logic/backend_top.sv ====
// Back-end top level: pipeline control, register read stage and two execute lanes.
`timescale 1ns/1ps

module backend_top import core_pkg::*; #(
    parameter logic [xlen-1:0] counter_id = 32'h0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  logic       flush,
    input  issue_uop_t issue0,
    input  issue_uop_t issue1,
    output logic       issue_ready,
    output wb_t        commit0,
    output wb_t        commit1
);

    logic      hold;
    logic      bubble;
    logic      kill;
    read_uop_t read0;
    read_uop_t read1;

    pipe_control u_pipe_control (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .flush       (flush),
        .issue0      (issue0),
        .issue1      (issue1),
        .read_rd0    (read0.rd),
        .read_rd1    (read1.rd),
        .read_valid0 (read0.valid),
        .read_valid1 (read1.valid),
        .hold        (hold),
        .bubble      (bubble),
        .kill        (kill),
        .issue_ready (issue_ready)
    );

    // Writeback feeds the register file and leaves as the commit ports.
    register_file #(.counter_id(counter_id)) u_register_file (
        .clk    (clk),
        .reset  (reset),
        .hold   (hold),
        .bubble (bubble),
        .kill   (kill),
        .issue0 (issue0),
        .issue1 (issue1),
        .wb0    (commit0),
        .wb1    (commit1),
        .read0  (read0),
        .read1  (read1)
    );

    exec_unit lane0 (.clk(clk), .reset(reset), .hold(hold), .kill(kill), .read_in(read0),
                     .wb(commit0));
    exec_unit lane1 (.clk(clk), .reset(reset), .hold(hold), .kill(kill), .read_in(read1),
                     .wb(commit1));

endmodule

// ==== testbench/backend_tb_tasks.svh ====
// Directed tests, random generator, reference ALU, issue driver and checks for the testbench.

function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
endfunction

task automatic check_value(input string name, input logic [31:0] want, input logic [31:0] got);
    assert (got === want)
    else begin
        errors++;
        $display("mismatch at %0t: %s expected %h actual %h", $time, name, want, got);
    end
endtask

task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1)
    else begin
        errors++;
        $display("error at %0t: %s", $time, what);
    end
endtask

function automatic issue_uop_t make_uop(input alu_op_e op, input src1_sel_e s1,
                                        input src2_sel_e s2, input logic [4:0] rd,
                                        input logic [4:0] rj, input logic [4:0] rk,
                                        input logic [31:0] imm);
    issue_uop_t u;
    u.valid    = 1'b1;
    u.op       = op;
    u.src1_sel = s1;
    u.src2_sel = s2;
    u.rd       = rd;
    u.rj       = rj;
    u.rk       = rk;
    u.imm      = imm;
    u.pc       = pc_next;
    pc_next    = pc_next + 32'd4;
    return u;
endfunction

// ----------------------------------------------------------------------
// Reference model
// ----------------------------------------------------------------------

function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] a,
                                        input logic [31:0] b);
    case (op)
        alu_add: return a + b;
        alu_sub: return a - b;
        alu_and: return a & b;
        alu_or:  return a | b;
        alu_xor: return a ^ b;
        alu_sll: return a << b[4:0];
        alu_srl: return a >> b[4:0];
        alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_lui: return {b[19:0], 12'd0};
        default: return 32'd0;
    endcase
endfunction

function automatic logic [31:0] reg_ref(input logic [4:0] r);
    return (r == 5'd0) ? 32'd0 : ref_regs[r];
endfunction

function automatic wb_t predict(input issue_uop_t u);
    logic [31:0] a;
    logic [31:0] b;
    wb_t w;
    case (u.src1_sel)
        src1_rf:   a = reg_ref(u.rj);
        src1_pc:   a = u.pc;
        src1_zero: a = 32'd0;
        default:   a = core_id;
    endcase
    case (u.src2_sel)
        src2_rf:   b = reg_ref(u.rk);
        src2_imm:  b = u.imm;
        src2_cntl: b = counter_model[31:0]; // Value seen at the accepting edge.
        default:   b = counter_model[63:32];
    endcase
    w.en   = 1'b1;
    w.rd   = u.rd;
    w.data = alu_ref(u.op, a, b);
    w.pc   = u.pc;
    return w;
endfunction

task automatic compare_commit(input int lane, input wb_t got);
    wb_t want;
    string name;
    name = $sformatf("commit%0d", lane);
    if ((lane == 0 && exp_q0.size() == 0) || (lane == 1 && exp_q1.size() == 0)) begin
        check_true(1'b0, {name, " fired with no micro-op expected"});
    end else begin
        if (lane == 0)
            want = exp_q0.pop_front();
        else
            want = exp_q1.pop_front();
        check_value({name, ".rd"}, 32'(want.rd), 32'(got.rd));
        check_value({name, ".data"}, want.data, got.data);
        check_value({name, ".pc"}, want.pc, got.pc);
    end
endtask

// ----------------------------------------------------------------------
// Issue driver
// ----------------------------------------------------------------------

// Offers a pair from the current rising edge until the DUT takes it.
task automatic send_pair(input issue_uop_t u0, input issue_uop_t u1, input bit track,
                         output int waits);
    wb_t w0;
    wb_t w1;
    waits = 0;
    issue0 <= u0;
    issue1 <= u1;
    @(negedge clk);
    while (!issue_ready && waits < 20) begin
        waits++;
        @(negedge clk);
    end
    check_true(issue_ready, "an issue pair was never accepted");
    if (track) begin
        w0 = predict(u0);
        w1 = predict(u1);
        exp_q0.push_back(w0);
        exp_q1.push_back(w1);
        if (u0.rd != 5'd0)
            ref_regs[u0.rd] = w0.data;
        if (u1.rd != 5'd0)
            ref_regs[u1.rd] = w1.data; // Lane 1 lands last and wins.
    end
    @(posedge clk);
endtask

task automatic wait_drain();
    int n;
    n = 0;
    issue0 <= '0;
    issue1 <= '0;
    while ((exp_q0.size() + exp_q1.size()) != 0 && n < 10) begin
        @(negedge clk);
        n++;
    end
    check_true((exp_q0.size() + exp_q1.size()) == 0, "an expected commit never arrived");
    @(posedge clk);
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------

task automatic test_reset_state();
    int waits;
    @(negedge clk);
    check_true(issue_ready, "issue_ready was low after reset");
    check_true(!commit0.en && !commit1.en, "a commit en bit was high after reset");
    @(posedge clk);
    send_pair(make_uop(alu_add, src1_rf, src2_rf, 5'd1, 5'd0, 5'd0, 32'd0),
              make_uop(alu_or, src1_rf, src2_imm, 5'd2, 5'd0, 5'd0, 32'd0), 1'b1, waits);
    wait_drain();
endtask

task automatic test_alu_ops();
    int waits;
    for (int i = 1; i < 9; i += 2)
        send_pair(make_uop(alu_add, src1_zero, src2_imm, 5'(i), 5'd0, 5'd0, lcg_next()),
                  make_uop(alu_add, src1_zero, src2_imm, 5'(i + 1), 5'd0, 5'd0, lcg_next()),
                  1'b1, waits);
    for (int op = 0; op < 9; op++)
        send_pair(make_uop(alu_op_e'(op), src1_rf, src2_rf, 5'(16 + op), 5'(1 + op % 8),
                           5'(8 - op % 8), 32'd0),
                  make_uop(alu_op_e'(op), src1_pc, src2_imm, 5'(25 + op % 4), 5'd0, 5'd0,
                           lcg_next()), 1'b1, waits);
    send_pair(make_uop(alu_add, src1_cntid, src2_imm, 5'd29, 5'd0, 5'd0, 32'd0),
              make_uop(alu_add, src1_zero, src2_cnth, 5'd30, 5'd0, 5'd0, 32'd0), 1'b1, waits);
    send_pair(make_uop(alu_add, src1_zero, src2_cntl, 5'd29, 5'd0, 5'd0, 32'd0),
              make_uop(alu_or, src1_zero, src2_cntl, 5'd30, 5'd0, 5'd0, 32'd0), 1'b1, waits);
    wait_drain();
endtask

task automatic test_raw_hazard();
    int waits;
    send_pair(make_uop(alu_add, src1_zero, src2_imm, 5'd14, 5'd0, 5'd0, lcg_next()),
              make_uop(alu_add, src1_zero, src2_imm, 5'd15, 5'd0, 5'd0, lcg_next()), 1'b1, waits);
    send_pair(make_uop(alu_sub, src1_rf, src2_rf, 5'd16, 5'd14, 5'd15, 32'd0),
              make_uop(alu_xor, src1_pc, src2_rf, 5'd17, 5'd0, 5'd15, 32'd0), 1'b1, waits);
    check_value("issue_ready low cycles", 32'd1, 32'(waits));
    send_pair(make_uop(alu_and, src1_rf, src2_imm, 5'd18, 5'd14, 5'd0, lcg_next()),
              make_uop(alu_sll, src1_rf, src2_imm, 5'd19, 5'd15, 5'd0, 32'd3), 1'b1, waits);
    check_value("issue_ready low cycles", 32'd0, 32'(waits));
    wait_drain();
endtask

task automatic test_dual_write();
    int waits;
    send_pair(make_uop(alu_add, src1_zero, src2_imm, 5'd9, 5'd0, 5'd0, lcg_next()),
              make_uop(alu_add, src1_zero, src2_imm, 5'd9, 5'd0, 5'd0, lcg_next()), 1'b1, waits);
    send_pair(make_uop(alu_add, src1_zero, src2_imm, 5'd0, 5'd0, 5'd0, 32'h5a5a_0001),
              make_uop(alu_or, src1_rf, src2_imm, 5'd21, 5'd9, 5'd0, 32'd0), 1'b1, waits);
    // The bubble on r21 lets register 0 be read while the dropped write is in writeback.
    send_pair(make_uop(alu_add, src1_rf, src2_rf, 5'd22, 5'd0, 5'd0, 32'd0),
              make_uop(alu_add, src1_rf, src2_rf, 5'd23, 5'd9, 5'd21, 32'd0), 1'b1, waits);
    check_value("issue_ready low cycles", 32'd1, 32'(waits));
    wait_drain();
endtask

task automatic test_stall();
    int waits;
    issue_uop_t p0;
    issue_uop_t p1;
    send_pair(make_uop(alu_add, src1_zero, src2_imm, 5'd10, 5'd0, 5'd0, lcg_next()),
              make_uop(alu_add, src1_zero, src2_imm, 5'd11, 5'd0, 5'd0, lcg_next()), 1'b1, waits);
    send_pair(make_uop(alu_add, src1_zero, src2_imm, 5'd12, 5'd0, 5'd0, lcg_next()),
              make_uop(alu_add, src1_pc, src2_imm, 5'd13, 5'd0, 5'd0, lcg_next()), 1'b1, waits);
    p0 = make_uop(alu_add, src1_rf, src2_rf, 5'd24, 5'd10, 5'd11, 32'd0);
    p1 = make_uop(alu_sub, src1_rf, src2_imm, 5'd25, 5'd12, 5'd0, lcg_next());
    issue0 <= p0;
    issue1 <= p1;
    stall  <= 1'b1;
    repeat (4) begin
        @(negedge clk);
        check_true(!issue_ready, "issue_ready was high during a stall");
    end
    @(posedge clk);
    stall <= 1'b0;
    send_pair(p0, p1, 1'b1, waits);
    send_pair(make_uop(alu_srl, src1_rf, src2_imm, 5'd26, 5'd13, 5'd0, 32'd5),
              make_uop(alu_slt, src1_rf, src2_rf, 5'd27, 5'd10, 5'd12, 32'd0), 1'b1, waits);
    wait_drain();
endtask

task automatic test_flush();
    int waits;
    issue_uop_t p0;
    issue_uop_t p1;
    // These two pairs are in flight when flush arrives and must vanish.
    send_pair(make_uop(alu_add, src1_zero, src2_imm, 5'd10, 5'd0, 5'd0, lcg_next()),
              make_uop(alu_add, src1_zero, src2_imm, 5'd11, 5'd0, 5'd0, lcg_next()), 1'b0, waits);
    send_pair(make_uop(alu_add, src1_zero, src2_imm, 5'd12, 5'd0, 5'd0, lcg_next()),
              make_uop(alu_add, src1_zero, src2_imm, 5'd13, 5'd0, 5'd0, lcg_next()), 1'b0, waits);
    p0 = make_uop(alu_add, src1_rf, src2_imm, 5'd26, 5'd10, 5'd0, 32'd0);
    p1 = make_uop(alu_or, src1_rf, src2_imm, 5'd27, 5'd11, 5'd0, 32'd0);
    issue0 <= p0;
    issue1 <= p1;
    flush  <= 1'b1;
    @(negedge clk);
    check_true(!issue_ready, "issue_ready was high during a flush");
    @(posedge clk);
    flush <= 1'b0;
    send_pair(p0, p1, 1'b1, waits);
    send_pair(make_uop(alu_add, src1_rf, src2_imm, 5'd28, 5'd12, 5'd0, 32'd0),
              make_uop(alu_add, src1_rf, src2_imm, 5'd29, 5'd13, 5'd0, 32'd0), 1'b1, waits);
    wait_drain();
endtask

// ==== testbench/backend_tb.sv ====
// Back-end testbench top: clock, reset, DUT, reference register model, commit monitor, timeout.
`timescale 1ns/1ps

module backend_tb import core_pkg::*; ();

    localparam logic [xlen-1:0] core_id = 32'hc0de_0001;
    // Reset, ALU, hazard, dual write, stall and flush tests, in cycles.
    localparam int test_cycles = 10 + 30 + 15 + 15 + 25 + 25;
    localparam int cycle_limit = 2 * test_cycles;

    logic            clk;
    logic            reset;
    logic            stall;
    logic            flush;
    issue_uop_t      issue0;
    issue_uop_t      issue1;
    logic            issue_ready;
    wb_t             commit0;
    wb_t             commit1;

    logic [xlen-1:0] ref_regs [32]; // Architectural state, in program order.
    logic [63:0]     counter_model;
    wb_t             exp_q0 [$];
    wb_t             exp_q1 [$];
    int              errors;
    int              cycle_count = 0;
    logic [31:0]     seed;
    logic [xlen-1:0] pc_next;

    backend_top #(.counter_id(core_id)) DUT (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .flush       (flush),
        .issue0      (issue0),
        .issue1      (issue1),
        .issue_ready (issue_ready),
        .commit0     (commit0),
        .commit1     (commit1)
    );

    `include "backend_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // The stable counter starts at zero out of reset and steps once per cycle.
    always @(posedge clk) begin
        if (reset)
            counter_model <= 64'd0;
        else
            counter_model <= counter_model + 64'd1;
    end

    // ----------------------------------------------------------------------
    // Commit monitor and watchdog
    // ----------------------------------------------------------------------

    always @(negedge clk) begin
        if (!reset) begin
            if (stall)
                check_true(!commit0.en && !commit1.en, "a commit appeared during a stall");
            if (commit0.en)
                compare_commit(0, commit0);
            if (commit1.en)
                compare_commit(1, commit1);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        seed    = 32'ha37b;
        errors  = 0;
        pc_next = 32'h0000_1000;
        reset   = 1'b1;
        stall   = 1'b0;
        flush   = 1'b0;
        issue0  = '0;
        issue1  = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_reset_state();
        test_alu_ops();
        test_raw_hazard();
        test_dual_write();
        test_stall();
        test_flush();
        $display("Run complete: %0d errors.", errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== compile.f ====
logic/core_pkg.sv
logic/pipe_control.sv
logic/register_file.sv
logic/exec_unit.sv
logic/backend_top.sv
+incdir+testbench
testbench/backend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the back-end testbench with Verilator, runs it and scans the log for failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module backend_tb -Mdir obj_dir -f compile.f

./obj_dir/Vbackend_tb | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "Simulation failed, see sim.log."
    exit 1
fi

echo "Simulation finished without failures."
